//--- hdl/hbi_decode_params.svh
`ifndef HBI_DECODE_PARAMS_SVH
`define HBI_DECODE_PARAMS_SVH

`define HB_ADDR_W        32         // host bus address width
`define HB_CMD_W         4          // host bus command width
`define CYC_W            2          // cycle class width

`define CYC_IO           2'b00      // i/o mapped
`define CYC_MEM          2'b01      // memory mapped
`define CYC_CFG          2'b10      // pci configuration
`define CYC_NONE         2'b11      // reserved, never claimed

`define CFG_IDX_W        4          // config register index width
`define CFG_IDX_CTRL     4'd0       // enable / vga control word
`define CFG_IDX_IOBASE   4'd1       // i/o base, bits 31:8
`define CFG_IDX_RBASE_G  4'd2       // global regs, bits 31:8
`define CFG_IDX_RBASE_W  4'd3       // window regs, bits 31:8
`define CFG_IDX_RBASE_A  4'd4       // drawing engine a, bits 31:9
`define CFG_IDX_RBASE_I  4'd5       // interrupt regs, bits 31:8
`define CFG_IDX_RBASE_E  4'd6       // eprom, bits 31:16
`define CFG_IDX_MW0      4'd7       // window 0 base + size
`define CFG_IDX_MW1      4'd8       // window 1 base + size
`define CFG_IDX_XYW      4'd9       // xy window base

`define VGA_IO_PAGE      24'h000003 // addr 31:8 of the vga ports
`define VGA_MEM_AB       15'h0005   // addr 31:17, a0000-bffff
`define VGA_MEM_A0       16'h000a   // addr 31:16, a0000-affff
`define VGA_MEM_B0       17'h00016  // addr 31:15, b0000-b7fff
`define VGA_MEM_B8       17'h00017  // addr 31:15, b8000-bffff

`define WIN_PAGE_LSB     12         // lowest window address bit
`define WIN_MASK_W       13         // size mask, 4K up to 32M

`endif

//--- hdl/hbi_decode_pkg.sv
`default_nettype none

`include "hbi_decode_params.svh"

package hbi_decode_pkg;

  typedef logic [`HB_ADDR_W-1:0] hb_addr_t;  // bus address
  typedef logic [`HB_CMD_W-1:0]  hb_cmd_t;   // bus command
  typedef logic [`CYC_W-1:0]     cycle_t;    // cycle class, CYC_* codes
  typedef logic [3:0]            win_size_t; // window size code

  // latched request from the bus front end
  typedef struct packed {
    hb_addr_t addr;
    hb_cmd_t  cmd;
    logic     idsel;                         // latched config select
  } hb_req_t;

  typedef struct packed {
    logic [23:0] io_base;                    // i/o base, addr 31:8
    logic [23:0] rbase_g;
    logic [23:0] rbase_w;
    logic [23:0] rbase_i;
    logic [22:0] rbase_a;                    // 512 byte block
    logic [15:0] rbase_e;                    // 64K eprom block
    logic [19:0] mw0_addr;
    win_size_t   mw0_size;
    logic [19:0] mw1_addr;
    win_size_t   mw1_size;
    logic [19:0] xyw_addr;
    logic        pci_io_en;
    logic        pci_mem_en;
    logic        pci_eprom_en;
    logic        en_g;
    logic        en_w;
    logic        en_a;
    logic        en_i;
    logic        en_e;
    logic        en_mw0;
    logic        en_mw1;
    logic        en_xy;
    logic        vga_global_en;
    logic        vga_mem_en;
    logic        vga_color_io;               // 1 = 3dx ports, 0 = 3bx
    logic        vga_class;                  // 0 = standard vga decode
    logic [1:0]  vga_decode_ctrl;            // vga memory range pick
  } decode_cfg_t;

  typedef struct packed {
    logic io_cyc;
    logic mem_cyc;
    logic cfg_cyc;
  } cycle_qual_t;

  // all active low
  typedef struct packed {
    logic blk_config;                        // i/o config block
    logic pci_cfg;
    logic global;
    logic window;
    logic draw_a;
    logic intr;
  } reg_cs_t;

  // all active low
  typedef struct packed {
    logic mem0;
    logic mem1;
    logic xyw;
    logic eprom;
    logic vga;
  } space_cs_t;

endpackage

`default_nettype wire

//--- hdl/hbi_decode_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "hbi_decode_params.svh"

module hbi_decode_regs (
  input  wire logic                     hb_clk,
  input  wire logic                     sys_reset_n,
  input  wire logic                     cfg_wr,      // one cycle write strobe
  input  wire logic [`CFG_IDX_W-1:0]    cfg_idx,
  input  wire hbi_decode_pkg::hb_addr_t cfg_data,
  output hbi_decode_pkg::decode_cfg_t   cfg
);
  import hbi_decode_pkg::*;

  decode_cfg_t cfg_rst;                              // power-up image

  // io, mem and eprom space come up open so the host can boot
  always_comb begin
    cfg_rst              = '0;
    cfg_rst.pci_io_en    = 1'b1;
    cfg_rst.pci_mem_en   = 1'b1;
    cfg_rst.pci_eprom_en = 1'b1;
    cfg_rst.en_e         = 1'b1;
  end

  always_ff @(posedge hb_clk) begin
    if (!sys_reset_n) begin
      cfg <= cfg_rst;
    end else if (cfg_wr) begin
      case (cfg_idx)
        `CFG_IDX_CTRL: begin                         // enables, lsb first
          cfg.pci_io_en       <= cfg_data[0];
          cfg.pci_mem_en      <= cfg_data[1];
          cfg.pci_eprom_en    <= cfg_data[2];
          cfg.en_g            <= cfg_data[3];
          cfg.en_w            <= cfg_data[4];
          cfg.en_a            <= cfg_data[5];
          cfg.en_i            <= cfg_data[6];
          cfg.en_e            <= cfg_data[7];
          cfg.en_mw0          <= cfg_data[8];
          cfg.en_mw1          <= cfg_data[9];
          cfg.en_xy           <= cfg_data[10];
          cfg.vga_global_en   <= cfg_data[11];
          cfg.vga_mem_en      <= cfg_data[12];
          cfg.vga_color_io    <= cfg_data[13];
          cfg.vga_class       <= cfg_data[14];
          cfg.vga_decode_ctrl <= cfg_data[16:15];
        end
        `CFG_IDX_IOBASE:  cfg.io_base <= cfg_data[31:8];
        `CFG_IDX_RBASE_G: cfg.rbase_g <= cfg_data[31:8];
        `CFG_IDX_RBASE_W: cfg.rbase_w <= cfg_data[31:8];
        `CFG_IDX_RBASE_A: cfg.rbase_a <= cfg_data[31:9];
        `CFG_IDX_RBASE_I: cfg.rbase_i <= cfg_data[31:8];
        `CFG_IDX_RBASE_E: cfg.rbase_e <= cfg_data[31:16];
        `CFG_IDX_MW0: begin
          cfg.mw0_addr <= cfg_data[`HB_ADDR_W-1:`WIN_PAGE_LSB];
          cfg.mw0_size <= cfg_data[3:0];             // size code in low nibble
        end
        `CFG_IDX_MW1: begin
          cfg.mw1_addr <= cfg_data[`HB_ADDR_W-1:`WIN_PAGE_LSB];
          cfg.mw1_size <= cfg_data[3:0];
        end
        `CFG_IDX_XYW:     cfg.xyw_addr <= cfg_data[`HB_ADDR_W-1:`WIN_PAGE_LSB];
        default: ;                                   // holes in the map
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/hbi_cycle_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "hbi_decode_params.svh"

module hbi_cycle_decode (
  input  wire logic                        sys_reset_n,
  input  wire hbi_decode_pkg::hb_req_t     req,
  input  wire hbi_decode_pkg::decode_cfg_t cfg,
  output hbi_decode_pkg::cycle_qual_t      qual
);
  import hbi_decode_pkg::*;

  cycle_t cyc;                                       // raw class of the command

  // int ack, special, dual address and reserved fall to none
  always_comb begin
    casez (req.cmd)
      4'b001?:                   cyc = `CYC_IO;
      4'b011?, 4'b111?, 4'b1100: cyc = `CYC_MEM;     // rd/wr, line, multiple
      4'b101?:                   cyc = `CYC_CFG;
      default:                   cyc = `CYC_NONE;
    endcase
  end

  // every strobe dies in reset so no select can fire
  always_comb begin
    qual.io_cyc  = sys_reset_n && cfg.pci_io_en && (cyc == `CYC_IO);
    qual.mem_cyc = sys_reset_n && cfg.pci_mem_en && (cyc == `CYC_MEM);
    qual.cfg_cyc = sys_reset_n && req.idsel && (cyc == `CYC_CFG) &&
                   (req.addr[1:0] == 2'b00);         // type 0 only
  end

endmodule

`default_nettype wire

//--- hdl/hbi_window_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "hbi_decode_params.svh"

module hbi_window_decode (
  input  wire hbi_decode_pkg::hb_req_t     req,
  input  wire hbi_decode_pkg::decode_cfg_t cfg,
  input  wire hbi_decode_pkg::cycle_qual_t qual,
  input  wire logic                        cs_blkbird_regs_n, // any reg block
  input  wire logic                        space_in,          // vga select
  output hbi_decode_pkg::space_cs_t        cs_space,
  output logic                             cs_windows_n,
  output logic                             cs_blkbird_n
);
  import hbi_decode_pkg::*;

  typedef logic [`HB_ADDR_W-1:`WIN_PAGE_LSB] win_page_t;
  typedef logic [`WIN_MASK_W-1:0]            win_mask_t;

  win_page_t page;                                   // 4K page of the request

  ////////////////////////////////////////////////////////////
  // size masked window compare
  ////////////////////////////////////////////////////////////

  // code n ignores the n low page bits, 14 and 15 saturate at 32M
  function automatic win_mask_t size_mask(input win_size_t size);
    win_mask_t m;
    for (int i = 0; i < `WIN_MASK_W; i++) begin
      m[i] = (size > win_size_t'(i));
    end
    return m;
  endfunction

  // windows are aligned to their own size
  function automatic logic win_hit(input win_page_t addr, input win_page_t base,
                                   input win_size_t size);
    win_page_t diff;
    diff = (addr ^ base) & ~win_page_t'(size_mask(size));
    return (diff == '0);
  endfunction

  assign page = req.addr[`HB_ADDR_W-1:`WIN_PAGE_LSB];

  always_comb begin
    cs_space.mem0  = !(qual.mem_cyc && cfg.en_mw0 &&
                       win_hit(page, cfg.mw0_addr, cfg.mw0_size));
    cs_space.mem1  = !(qual.mem_cyc && cfg.en_mw1 &&
                       win_hit(page, cfg.mw1_addr, cfg.mw1_size));
    cs_space.xyw   = !(qual.mem_cyc && cfg.en_xy && (page == cfg.xyw_addr)); // exact page
    cs_space.eprom = !(qual.mem_cyc && cfg.en_e && cfg.pci_eprom_en &&
                       (req.addr[31:16] == cfg.rbase_e));
    cs_space.vga   = space_in;                       // decoded next door
  end

  ////////////////////////////////////////////////////////////
  // combined selects
  ////////////////////////////////////////////////////////////

  assign cs_windows_n = cs_space.mem0 && cs_space.mem1;
  assign cs_blkbird_n = cs_blkbird_regs_n && cs_space.xyw && cs_windows_n; // any resource

endmodule

`default_nettype wire

//--- hdl/hbi_reg_block_decode.sv
`timescale 1ns/100ps
`default_nettype none

module hbi_reg_block_decode (
  input  wire logic                        hb_clk,
  input  wire hbi_decode_pkg::hb_req_t     req,
  input  wire hbi_decode_pkg::decode_cfg_t cfg,
  input  wire hbi_decode_pkg::cycle_qual_t qual,
  input  wire logic                        cs_vga_n,
  output hbi_decode_pkg::reg_cs_t          cs_regs_un,        // combinational
  output hbi_decode_pkg::reg_cs_t          cs_regs_n,         // hb_clk copy
  output logic                             cs_blkbird_regs_n
);
  import hbi_decode_pkg::*;

  hb_addr_t a;                                       // request address
  logic     cfg_gap;                                 // dac shadow gap at 0x80-0xbf
  logic     glb_range;                               // global offsets in use

  assign a = req.addr;

  assign cfg_gap   = (a[7:6] == 2'b10);
  assign glb_range = ((a[7:0] >= 8'h20) && (a[7:0] <= 8'h6f)) ||
                     (a[7:0] >= 8'hb0);

  ////////////////////////////////////////////////////////////
  // block selects straight off the latched request
  ////////////////////////////////////////////////////////////

  always_comb begin
    cs_regs_un.blk_config = !(qual.io_cyc && (a[31:8] == cfg.io_base) && !cfg_gap);
    cs_regs_un.pci_cfg    = !qual.cfg_cyc;           // idsel already folded in
    cs_regs_un.global     = !(qual.mem_cyc && cfg.en_g && cs_vga_n &&
                              (a[31:8] == cfg.rbase_g) && glb_range);
    cs_regs_un.window     = !(qual.mem_cyc && cfg.en_w &&
                              (a[31:8] == cfg.rbase_w));
    cs_regs_un.draw_a     = !(qual.mem_cyc && cfg.en_a &&
                              (a[31:9] == cfg.rbase_a));  // 512 byte block
    cs_regs_un.intr       = !(qual.mem_cyc && cfg.en_i &&
                              (a[31:8] == cfg.rbase_i));
  end

  assign cs_blkbird_regs_n = &cs_regs_un;            // low if any block hit

  ////////////////////////////////////////////////////////////
  // register side copies
  ////////////////////////////////////////////////////////////

  // block selects one cycle late for the register side
  always_ff @(posedge hb_clk) begin
    cs_regs_n <= cs_regs_un;
  end

endmodule

`default_nettype wire

//--- hdl/hbi_vga_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "hbi_decode_params.svh"

module hbi_vga_decode (
  input  wire hbi_decode_pkg::hb_req_t     req,
  input  wire hbi_decode_pkg::decode_cfg_t cfg,
  input  wire hbi_decode_pkg::cycle_qual_t qual,
  output logic                             cs_vga_n
);
  import hbi_decode_pkg::*;

  hb_addr_t a;
  logic     io_hit;                                  // legacy port match
  logic     mem_hit;                                 // frame buffer match

  assign a = req.addr;

  // 3c6-3c9 belong to the dac, not to this space
  always_comb begin
    io_hit = 1'b0;
    if (a[31:8] == `VGA_IO_PAGE) begin
      case (a[7:4])
        4'hc:    io_hit = !(a[3:0] inside {4'h3, 4'h6, 4'h7, 4'h8, 4'h9,
                                           4'hb, 4'hd});
        4'hb:    io_hit = !cfg.vga_color_io &&       // mono crtc + status
                          (a[3:0] inside {4'h4, 4'h5, 4'ha});
        4'hd:    io_hit = cfg.vga_color_io &&        // color crtc + status
                          (a[3:0] inside {4'h4, 4'h5, 4'ha});
        default: io_hit = 1'b0;
      endcase
    end
  end

  always_comb begin
    case (cfg.vga_decode_ctrl)
      2'd0:    mem_hit = (a[31:17] == `VGA_MEM_AB);  // a0000-bffff
      2'd1:    mem_hit = (a[31:16] == `VGA_MEM_A0);  // a0000-affff
      2'd2:    mem_hit = (a[31:15] == `VGA_MEM_B0);  // b0000-b7fff
      default: mem_hit = (a[31:15] == `VGA_MEM_B8);  // b8000-bffff
    endcase
  end

  // extended class parts leave legacy space alone
  assign cs_vga_n = !(cfg.vga_global_en && !cfg.vga_class &&
                      ((qual.io_cyc && io_hit) ||
                       (qual.mem_cyc && cfg.vga_mem_en && mem_hit)));

endmodule

`default_nettype wire

//--- hdl/hbi_addr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "hbi_decode_params.svh"

module hbi_addr_decoder (
  input  wire logic                     hb_clk,
  input  wire logic                     sys_reset_n,
  input  wire hbi_decode_pkg::hb_req_t  hb_req,            // latched request
  input  wire logic                     cfg_wr,
  input  wire logic [`CFG_IDX_W-1:0]    cfg_idx,
  input  wire hbi_decode_pkg::hb_addr_t cfg_data,
  output hbi_decode_pkg::space_cs_t     cs_space,
  output hbi_decode_pkg::reg_cs_t       cs_regs_un,
  output hbi_decode_pkg::reg_cs_t       cs_regs_n,
  output logic                          cs_windows_n,
  output logic                          cs_blkbird_regs_n,
  output logic                          cs_blkbird_n
);
  import hbi_decode_pkg::*;

  decode_cfg_t cfg;                                  // bases, sizes, enables
  cycle_qual_t qual;                                 // qualified cycle strobes
  logic        cs_vga_n;

  hbi_decode_regs regs_i (
    .hb_clk      (hb_clk),
    .sys_reset_n (sys_reset_n),
    .cfg_wr      (cfg_wr),
    .cfg_idx     (cfg_idx),
    .cfg_data    (cfg_data),
    .cfg         (cfg)
  );

  hbi_cycle_decode cycle_i (
    .sys_reset_n (sys_reset_n),
    .req         (hb_req),
    .cfg         (cfg),
    .qual        (qual)
  );

  hbi_vga_decode vga_i (
    .req      (hb_req),
    .cfg      (cfg),
    .qual     (qual),
    .cs_vga_n (cs_vga_n)
  );

  // vga hit masks the global block
  hbi_reg_block_decode reg_blk_i (
    .hb_clk            (hb_clk),
    .req               (hb_req),
    .cfg               (cfg),
    .qual              (qual),
    .cs_vga_n          (cs_vga_n),
    .cs_regs_un        (cs_regs_un),
    .cs_regs_n         (cs_regs_n),
    .cs_blkbird_regs_n (cs_blkbird_regs_n)
  );

  hbi_window_decode window_i (
    .req               (hb_req),
    .cfg               (cfg),
    .qual              (qual),
    .cs_blkbird_regs_n (cs_blkbird_regs_n),
    .space_in          (cs_vga_n),
    .cs_space          (cs_space),
    .cs_windows_n      (cs_windows_n),
    .cs_blkbird_n      (cs_blkbird_n)
  );

endmodule

`default_nettype wire

//--- bench/hbi_decode_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "hbi_decode_params.svh"

module hbi_decode_checker (
  input  wire logic                      hb_clk,
  input  wire logic                      sys_reset_n,
  input  wire hbi_decode_pkg::hb_req_t   hb_req,
  input  wire logic                      cfg_wr,
  input  wire logic [`CFG_IDX_W-1:0]     cfg_idx,
  input  wire hbi_decode_pkg::hb_addr_t  cfg_data,
  input  wire hbi_decode_pkg::space_cs_t cs_space,
  input  wire hbi_decode_pkg::reg_cs_t   cs_regs_un,
  input  wire hbi_decode_pkg::reg_cs_t   cs_regs_n,
  input  wire logic                      cs_windows_n,
  input  wire logic                      cs_blkbird_regs_n,
  input  wire logic                      cs_blkbird_n,
  output int                             error_count,
  output int                             check_count
);
  import hbi_decode_pkg::*;

  decode_cfg_t m;                                    // mirror of the config block
  hb_addr_t    a;
  logic [7:0]  off;                                  // offset inside a 256 byte block
  logic        io;
  logic        mem;
  logic        cfgc;
  logic        io_port;                              // legacy vga port
  logic        vmem;                                 // legacy vga memory
  logic        vga_hit;
  logic        mw0_hit;
  logic        mw1_hit;
  logic        xy_hit;
  logic        ep_hit;
  logic [5:0]  exp_regs;                             // config .. intr, active low
  logic [5:0]  exp_regs_q;                           // one cycle old copy
  logic [4:0]  exp_space;                            // mem0 .. vga, active low
  logic        primed = 1'b0;                        // history of exp_regs valid
  int          errs = 0;
  int          checks = 0;

  assign error_count = errs;
  assign check_count = checks;

  // size code n drops n page bits, capped at 13
  function automatic logic win_match(input logic [19:0] page, input logic [19:0] base,
                                     input logic [3:0] size);
    int n;
    n = (size > 4'd13) ? 13 : int'(size);
    return ((page ^ base) >> n) == 20'd0;
  endfunction

  ////////////////////////////////////////////////////////////
  // config mirror
  ////////////////////////////////////////////////////////////

  always @(posedge hb_clk) begin
    if (!sys_reset_n) begin
      m              <= '0;
      m.pci_io_en    <= 1'b1;                        // host spaces open after reset
      m.pci_mem_en   <= 1'b1;
      m.pci_eprom_en <= 1'b1;
      m.en_e         <= 1'b1;
    end else if (cfg_wr) begin
      case (cfg_idx)
        `CFG_IDX_CTRL: begin
          {m.vga_class, m.vga_color_io, m.vga_mem_en, m.vga_global_en, m.en_xy,
           m.en_mw1, m.en_mw0, m.en_e, m.en_i, m.en_a, m.en_w, m.en_g,
           m.pci_eprom_en, m.pci_mem_en, m.pci_io_en} <= cfg_data[14:0];
          m.vga_decode_ctrl <= cfg_data[16:15];
        end
        `CFG_IDX_IOBASE:  m.io_base <= cfg_data[31:8];
        `CFG_IDX_RBASE_G: m.rbase_g <= cfg_data[31:8];
        `CFG_IDX_RBASE_W: m.rbase_w <= cfg_data[31:8];
        `CFG_IDX_RBASE_A: m.rbase_a <= cfg_data[31:9];
        `CFG_IDX_RBASE_I: m.rbase_i <= cfg_data[31:8];
        `CFG_IDX_RBASE_E: m.rbase_e <= cfg_data[31:16];
        `CFG_IDX_MW0: begin
          m.mw0_addr <= cfg_data[31:12];
          m.mw0_size <= cfg_data[3:0];
        end
        `CFG_IDX_MW1: begin
          m.mw1_addr <= cfg_data[31:12];
          m.mw1_size <= cfg_data[3:0];
        end
        `CFG_IDX_XYW:     m.xyw_addr <= cfg_data[31:12];
        default: ;                                   // unused index
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // expected selects
  ////////////////////////////////////////////////////////////

  always_comb begin
    a    = hb_req.addr;
    off  = a[7:0];
    io   = sys_reset_n && m.pci_io_en && (hb_req.cmd[3:1] == 3'b001);
    mem  = sys_reset_n && m.pci_mem_en &&
           (hb_req.cmd[3:1] == 3'b011 || hb_req.cmd[3:1] == 3'b111 || hb_req.cmd == 4'b1100);
    cfgc = sys_reset_n && hb_req.idsel && (hb_req.cmd[3:1] == 3'b101) && (a[1:0] == 2'b00);
    io_port = (a[31:8] == 24'h3) &&
              ((off[7:4] == 4'hc && !(off == 8'hc3 || (off >= 8'hc6 && off <= 8'hc9) ||
                                      off == 8'hcb || off == 8'hcd)) ||
               (!m.vga_color_io && (off == 8'hb4 || off == 8'hb5 || off == 8'hba)) ||
               (m.vga_color_io && (off == 8'hd4 || off == 8'hd5 || off == 8'hda)));
    case (m.vga_decode_ctrl)
      2'd0:    vmem = (a >= 32'h000a_0000) && (a <= 32'h000b_ffff);
      2'd1:    vmem = (a >= 32'h000a_0000) && (a <= 32'h000a_ffff);
      2'd2:    vmem = (a >= 32'h000b_0000) && (a <= 32'h000b_7fff);
      default: vmem = (a >= 32'h000b_8000) && (a <= 32'h000b_ffff);
    endcase
    vga_hit = m.vga_global_en && !m.vga_class &&
              ((io && io_port) || (mem && m.vga_mem_en && vmem));
    mw0_hit = mem && m.en_mw0 && win_match(a[31:12], m.mw0_addr, m.mw0_size);
    mw1_hit = mem && m.en_mw1 && win_match(a[31:12], m.mw1_addr, m.mw1_size);
    xy_hit  = mem && m.en_xy && (a[31:12] == m.xyw_addr);
    ep_hit  = mem && m.en_e && m.pci_eprom_en && (a[31:16] == m.rbase_e);
    exp_regs[5] = !(io && (a[31:8] == m.io_base) && !(off >= 8'h80 && off <= 8'hbf));
    exp_regs[4] = !cfgc;
    exp_regs[3] = !(mem && m.en_g && !vga_hit && (a[31:8] == m.rbase_g) &&
                    ((off >= 8'h20 && off <= 8'h6f) || off >= 8'hb0));
    exp_regs[2] = !(mem && m.en_w && (a[31:8] == m.rbase_w));
    exp_regs[1] = !(mem && m.en_a && (a[31:9] == m.rbase_a));
    exp_regs[0] = !(mem && m.en_i && (a[31:8] == m.rbase_i));
    exp_space   = ~{mw0_hit, mw1_hit, xy_hit, ep_hit, vga_hit};
  end

  task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] got);
    checks++;
    if (exp !== got) begin
      errs++;
      $display("ERROR %s: expected %h, got %h at %0t", name, exp, got, $time);
    end
  endtask

  // sampled at the rising edge, inputs moved half a cycle earlier
  always @(posedge hb_clk) begin
    compare("cs_space", {3'b0, exp_space}, {3'b0, cs_space});
    compare("cs_regs_un", {2'b0, exp_regs}, {2'b0, cs_regs_un});
    compare("cs_windows_n", {7'b0, exp_space[4] & exp_space[3]}, {7'b0, cs_windows_n});
    compare("cs_blkbird_regs_n", {7'b0, &exp_regs}, {7'b0, cs_blkbird_regs_n});
    compare("cs_blkbird_n", {7'b0, &{exp_regs, exp_space[4:2]}}, {7'b0, cs_blkbird_n});
    if (primed) begin
      compare("cs_regs_n", {2'b0, exp_regs_q}, {2'b0, cs_regs_n});
    end
    exp_regs_q <= exp_regs;
    primed     <= 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/tb_hbi_addr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "hbi_decode_params.svh"

module tb_hbi_addr_decoder;
  import hbi_decode_pkg::*;

  localparam int RST_CYC  = 10;
  localparam int WIN_RUNS = 8;                       // random window setups
  localparam int WIN_CYC  = 120;                     // per enable phase
  localparam int REG_CYC  = 400;
  localparam int CMD_CYC  = 400;
  localparam int VGA_CYC  = 40;                      // per ctrl / color / gate combo
  localparam int MIX_RUNS = 6;
  localparam int MIX_CYC  = 50;
  // all test cycles, config writes and test gaps included
  localparam int TOTAL_CYC = RST_CYC + 20 + WIN_RUNS * (3 * WIN_CYC + 5) + REG_CYC +
                             CMD_CYC + 32 * (VGA_CYC + 1) + MIX_RUNS * (2 * MIX_CYC + 11) +
                             40;

  logic                  hb_clk;
  logic                  sys_reset_n;
  hb_req_t               hb_req;
  logic                  cfg_wr;
  logic [`CFG_IDX_W-1:0] cfg_idx;
  hb_addr_t              cfg_data;
  space_cs_t             cs_space;
  reg_cs_t               cs_regs_un;
  reg_cs_t               cs_regs_n;
  logic                  cs_windows_n;
  logic                  cs_blkbird_regs_n;
  logic                  cs_blkbird_n;
  int                    error_count;
  int                    check_count;
  int                    tests_run = 0;
  int                    tests_failed = 0;
  hb_addr_t              bias_base [8];              // bases that traffic aims at

  hbi_addr_decoder dut_i (.*);

  hbi_decode_checker chk_i (.*);

  initial begin
    hb_clk = 1'b0;
    forever #10 hb_clk = ~hb_clk;                    // 50 MHz
  end

  initial begin
    #(TOTAL_CYC * 20 + 4000);                        // full budget plus 200 cycles
    $display("watchdog: run did not finish within the cycle budget of %0d", TOTAL_CYC);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers driven on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic step(input hb_addr_t addr, input hb_cmd_t cmd, input logic idsel);
    @(negedge hb_clk);
    cfg_wr       = 1'b0;
    hb_req.addr  = addr;
    hb_req.cmd   = cmd;
    hb_req.idsel = idsel;
  endtask

  task automatic cfg_write(input logic [`CFG_IDX_W-1:0] idx, input hb_addr_t data);
    @(negedge hb_clk);
    cfg_wr   = 1'b1;                                 // dropped by the next step
    cfg_idx  = idx;
    cfg_data = data;
  endtask

  // half anywhere, half near a programmed base
  function automatic hb_addr_t pick_addr();
    int       sh;
    hb_addr_t span;
    if ($urandom_range(1, 0) == 0) begin
      return $urandom;
    end
    sh   = ($urandom_range(3, 0) == 0) ? $urandom_range(26, 10) : $urandom_range(9, 6);
    span = (32'h1 << sh) - 32'h1;
    return bias_base[3'($urandom)] ^ ($urandom & span);
  endfunction

  function automatic hb_cmd_t mem_cmd();
    hb_cmd_t codes [5] = '{4'h6, 4'h7, 4'he, 4'hf, 4'hc};
    return codes[$urandom_range(4, 0)];
  endfunction

  // kind 0 memory, 1 memory or i/o, 2 any command with random idsel
  task automatic traffic(input int n, input int kind);
    hb_addr_t ad;
    hb_cmd_t  c;
    repeat (n) begin
      ad = pick_addr();
      case (kind)
        0:       c = mem_cmd();
        1:       c = ($urandom_range(1, 0) == 1) ? mem_cmd() : {3'b001, 1'($urandom)};
        default: c = 4'($urandom);
      endcase
      if (kind == 2 && $urandom_range(1, 0) == 1) begin
        ad[1:0] = 2'b00;                             // type 0 config alignment
      end
      step(ad, c, (kind == 2) ? 1'($urandom) : 1'b0);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int errs;
    @(negedge hb_clk);
    cfg_wr = 1'b0;
    @(negedge hb_clk);                               // let the cs_regs_n check land
    errs = error_count - errs_before;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %-10s %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int       e0;
    hb_addr_t c;
    void'($urandom(32'h62c31887));
    sys_reset_n = 1'b0;
    hb_req      = '0;
    cfg_wr      = 1'b0;
    cfg_idx     = '0;
    cfg_data    = '0;
    for (int i = 0; i < 8; i++) begin
      bias_base[i] = '0;                             // reset bases are all zero
    end

    // traffic that would hit once reset is released
    e0 = error_count;
    traffic(RST_CYC - 1, 2);
    @(negedge hb_clk);
    sys_reset_n = 1'b1;
    traffic(20, 2);
    finish_test("reset", e0);

    e0 = error_count;
    repeat (WIN_RUNS) begin
      for (int i = 0; i < 8; i++) begin
        bias_base[i] = $urandom;                     // size code rides in bits 3:0
      end
      cfg_write(`CFG_IDX_MW0, bias_base[0]);
      cfg_write(`CFG_IDX_MW1, bias_base[1]);
      bias_base[2] = bias_base[0];
      bias_base[3] = bias_base[1];
      cfg_write(`CFG_IDX_CTRL, 32'h0000_0303);       // io, mem, mw0, mw1
      traffic(WIN_CYC, 0);
      cfg_write(`CFG_IDX_CTRL, 32'h0000_0203);       // mw0 off
      traffic(WIN_CYC, 0);
      cfg_write(`CFG_IDX_CTRL, 32'h0000_0301);       // memory space off
      traffic(WIN_CYC, 0);
    end
    finish_test("windows", e0);

    e0 = error_count;
    for (int i = 0; i < 8; i++) begin
      bias_base[i] = $urandom & 32'hffff_ff00;
    end
    bias_base[5] = bias_base[3] | 32'h0000_0100;     // upper half of draw_a block
    cfg_write(`CFG_IDX_IOBASE, bias_base[0]);
    cfg_write(`CFG_IDX_RBASE_G, bias_base[1]);
    cfg_write(`CFG_IDX_RBASE_W, bias_base[2]);
    cfg_write(`CFG_IDX_RBASE_A, bias_base[3]);
    cfg_write(`CFG_IDX_RBASE_I, bias_base[4]);
    cfg_write(`CFG_IDX_CTRL, 32'h0000_007b);         // io, mem, g, w, a, i
    traffic(REG_CYC, 1);
    finish_test("reg_blocks", e0);

    e0 = error_count;
    traffic(CMD_CYC, 2);
    finish_test("commands", e0);

    e0 = error_count;
    bias_base = '{32'h0000_03b0, 32'h0000_03c0, 32'h0000_03d0, 32'h000a_0000,
                  32'h000b_0000, 32'h000b_8000, 32'h000a_ffc0, 32'h000b_7fc0};
    cfg_write(`CFG_IDX_RBASE_G, 32'h000a_0000);      // global block under vga memory
    for (int dec = 0; dec < 4; dec++) begin
      for (int col = 0; col < 2; col++) begin
        for (int gate = 0; gate < 4; gate++) begin   // bit 0 global en, bit 1 class
          c = 32'h0000_100b | (32'(gate & 1) << 11) | (32'(col) << 13) |
              (32'(gate >> 1) << 14) | (32'(dec) << 15);
          cfg_write(`CFG_IDX_CTRL, c);
          traffic(VGA_CYC, 1);
        end
      end
    end
    finish_test("vga", e0);

    e0 = error_count;
    repeat (MIX_RUNS) begin
      for (int i = 0; i < 8; i++) begin
        bias_base[i] = $urandom;
      end
      for (int i = 1; i <= 9; i++) begin
        cfg_write(4'(i), bias_base[3'(i)]);
      end
      c = $urandom | 32'h0000_0003;                  // keep io and mem open
      cfg_write(`CFG_IDX_CTRL, c);
      traffic(MIX_CYC, 2);
      cfg_write(`CFG_IDX_CTRL, c ^ 32'h0000_0004);   // flip pci_eprom_en
      traffic(MIX_CYC, 2);
    end
    finish_test("mixed", e0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/hbi_decode_pkg.sv
hdl/hbi_decode_regs.sv
hdl/hbi_cycle_decode.sv
hdl/hbi_window_decode.sv
hdl/hbi_reg_block_decode.sv
hdl/hbi_vga_decode.sv
hdl/hbi_addr_decoder.sv
bench/hbi_decode_checker.sv
bench/tb_hbi_addr_decoder.sv

//--- run_sim.sh
#!/bin/sh
# build and run the address decoder testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing -f filelist.f --top-module tb_hbi_addr_decoder -Mdir "$OBJ"; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_hbi_addr_decoder" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
